//--- hw/tdc_ctrl_pkg.sv
package tdc_ctrl_pkg;

  // tdc front ends driven by the board
  localparam int NUM_TDC = 6;

  // uart bit period in clocks, sized for simulation
  localparam int CLK_PER_BIT = 16;
  localparam int BIT_CNT_W = $clog2(CLK_PER_BIT);
  // last count of a full bit and of half a bit
  localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLK_PER_BIT - 1);
  localparam logic [BIT_CNT_W-1:0] HALF_BIT_LAST = BIT_CNT_W'(CLK_PER_BIT / 2 - 1);

  // receiver fsm codes
  localparam int RX_STATE_W = 3;
  localparam logic [RX_STATE_W-1:0] RX_IDLE      = 3'd0;
  localparam logic [RX_STATE_W-1:0] RX_START     = 3'd1;
  localparam logic [RX_STATE_W-1:0] RX_DATA      = 3'd2;
  localparam logic [RX_STATE_W-1:0] RX_STOP      = 3'd3;
  localparam logic [RX_STATE_W-1:0] RX_WAIT_HIGH = 3'd4;

  // stands in for the ~2 ms tdc boot time
  localparam int BOOT_WAIT_CYCLES = 200;
  // settle time between boot and soft reset
  localparam int SOFT_RESET_DELAY = 50;
  localparam int SEQ_COUNT_W = $clog2(
    (BOOT_WAIT_CYCLES > SOFT_RESET_DELAY ? BOOT_WAIT_CYCLES : SOFT_RESET_DELAY) + 1);
  localparam logic [SEQ_COUNT_W-1:0] BOOT_LAST = SEQ_COUNT_W'(BOOT_WAIT_CYCLES - 1);
  localparam logic [SEQ_COUNT_W-1:0] SETTLE_LAST = SEQ_COUNT_W'(SOFT_RESET_DELAY);

  // host command characters
  localparam logic [7:0] CMD_POWER_ON = 8'h64;
  localparam logic [7:0] CMD_EXIT     = 8'h68;
  localparam logic [7:0] CMD_PAUSE    = 8'h70;

  // sequencer fsm codes
  localparam logic [1:0] ST_IDLE       = 2'd0;
  localparam logic [1:0] ST_BOOT_WAIT  = 2'd1;
  localparam logic [1:0] ST_SOFT_RESET = 2'd2;

endpackage

//--- hw/serial_rx.sv
`timescale 1ns/1ps

module serial_rx
  import tdc_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic [7:0] data,
  output logic       new_data
);

  // line after the two-flop synchronizer
  logic                  rx_meta;
  logic                  rx_sync;

  logic [RX_STATE_W-1:0] state;
  // clocks within the current bit
  logic [BIT_CNT_W-1:0]  bit_cnt;
  // data bit being received
  logic [2:0]            bit_idx;
  logic                  sample_data;

  // async line into clk domain
  always_ff @(posedge clk) begin
    if (rst) begin
      // idle level, so no false start after reset
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // mid-bit sample point of a data bit
  assign sample_data = (state == RX_DATA) && (bit_cnt == BIT_LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RX_IDLE;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      new_data <= 1'b0;
    end else begin
      // strobe lasts one cycle only
      new_data <= 1'b0;
      case (state)
        RX_IDLE: begin
          bit_cnt <= '0;
          bit_idx <= '0;
          // line is high here, so low means a falling edge
          if (!rx_sync) begin
            state <= RX_START;
          end
        end

        RX_START: begin
          if (bit_cnt == HALF_BIT_LAST) begin
            bit_cnt <= '0;
            // glitch if start bit gone by its middle
            if (!rx_sync) begin
              state <= RX_DATA;
            end else begin
              state <= RX_IDLE;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        RX_DATA: begin
          if (bit_cnt == BIT_LAST) begin
            bit_cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        RX_STOP: begin
          if (bit_cnt == BIT_LAST) begin
            bit_cnt <= '0;
            if (rx_sync) begin
              new_data <= 1'b1;
              state    <= RX_IDLE;
            end else begin
              // framing error, drop the byte
              state <= RX_WAIT_HIGH;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        RX_WAIT_HIGH: begin
          // hold off until the line is released
          if (rx_sync) begin
            state <= RX_IDLE;
          end
        end

        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // lsb first, shifted in from the top
  always_ff @(posedge clk) begin
    if (sample_data) begin
      data <= {rx_sync, data[7:1]};
    end
  end

endmodule

//--- hw/main_control.sv
`timescale 1ns/1ps

module main_control
  import tdc_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               serial_in,
  output logic [NUM_TDC-1:0] tdc_enable,
  output logic [NUM_TDC-1:0] soft_reset,
  output logic               exit,
  output logic               pause
);

  // received byte and its one-cycle strobe
  logic [7:0]             rx_data;
  logic                   rx_valid;

  // decoded commands, valid with the strobe only
  logic                   cmd_power_on;
  logic                   cmd_exit;
  logic                   cmd_pause;

  // sequencer
  logic [1:0]             state_q;
  logic [1:0]             state_d;
  logic [SEQ_COUNT_W-1:0] count_q;
  logic [SEQ_COUNT_W-1:0] count_d;

  // shared control levels
  logic                   enable_q;
  logic                   enable_d;
  logic                   soft_reset_q;
  logic                   soft_reset_d;
  logic                   exit_q;
  logic                   exit_d;
  logic                   pause_q;
  logic                   pause_d;

  serial_rx rx_uart (
    .clk      (clk),
    .rst      (rst),
    .rx       (serial_in),
    .data     (rx_data),
    .new_data (rx_valid)
  );

  assign cmd_power_on = rx_valid && (rx_data == CMD_POWER_ON);
  assign cmd_exit     = rx_valid && (rx_data == CMD_EXIT);
  assign cmd_pause    = rx_valid && (rx_data == CMD_PAUSE);

  always_comb begin
    state_d      = state_q;
    count_d      = count_q;
    enable_d     = enable_q;
    exit_d       = exit_q;
    pause_d      = pause_q;
    // pulse unless the sequencer fires below
    soft_reset_d = 1'b0;

    case (state_q)
      ST_IDLE: begin
        count_d = '0;
      end

      ST_BOOT_WAIT: begin
        // enable back up one cycle after the dip
        enable_d = 1'b1;
        if (count_q == BOOT_LAST) begin
          state_d = ST_SOFT_RESET;
          count_d = '0;
        end else begin
          count_d = count_q + 1'b1;
        end
      end

      ST_SOFT_RESET: begin
        // settle delay, then one soft reset pulse to every tdc
        if (count_q == SETTLE_LAST) begin
          soft_reset_d = 1'b1;
          state_d      = ST_IDLE;
          count_d      = '0;
        end else begin
          count_d = count_q + 1'b1;
        end
      end

      default: begin
        state_d = ST_IDLE;
        count_d = '0;
      end
    endcase

    // power-on wins over the running sequence
    if (cmd_power_on) begin
      enable_d     = 1'b0;
      exit_d       = 1'b0;
      soft_reset_d = 1'b0;
      state_d      = ST_BOOT_WAIT;
      count_d      = '0;
    end

    if (cmd_exit) begin
      exit_d = 1'b1;
    end

    if (cmd_pause) begin
      pause_d = ~pause_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_IDLE;
      count_q      <= '0;
      enable_q     <= 1'b0;
      soft_reset_q <= 1'b0;
      exit_q       <= 1'b0;
      pause_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      count_q      <= count_d;
      enable_q     <= enable_d;
      soft_reset_q <= soft_reset_d;
      exit_q       <= exit_d;
      pause_q      <= pause_d;
    end
  end

  // one enable and one reset shared by all channels
  assign tdc_enable = {NUM_TDC{enable_q}};
  assign soft_reset = {NUM_TDC{soft_reset_q}};
  assign exit       = exit_q;
  assign pause      = pause_q;

endmodule

//--- hw/tdc_ctrl_top.sv
`timescale 1ns/1ps

module tdc_ctrl_top
  import tdc_ctrl_pkg::*;
(
  // board clock and synchronous reset
  input  logic               clk,
  input  logic               rst,
  // host uart line, idles high
  input  logic               serial_in,
  // per-channel tdc enable pins
  output logic [NUM_TDC-1:0] tdc_enable,
  // per-channel tdc soft reset pins
  output logic [NUM_TDC-1:0] soft_reset,
  // levels to the acquisition side
  output logic               exit,
  output logic               pause
);

  // board-side copies of the controller outputs
  logic [NUM_TDC-1:0] ctrl_enable;
  logic [NUM_TDC-1:0] ctrl_soft_reset;
  logic               ctrl_exit;
  logic               ctrl_pause;

  // command decode and power-on sequencing
  main_control ctrl (
    .clk        (clk),
    .rst        (rst),
    .serial_in  (serial_in),
    .tdc_enable (ctrl_enable),
    .soft_reset (ctrl_soft_reset),
    .exit       (ctrl_exit),
    .pause      (ctrl_pause)
  );

  // straight to the pins, no added latency
  assign tdc_enable = ctrl_enable;
  assign soft_reset = ctrl_soft_reset;
  assign exit       = ctrl_exit;
  assign pause      = ctrl_pause;

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 40 ns period
  localparam int HALF_PERIOD_NS = 20;

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD_NS);
      clk = ~clk;
    end
  end

endmodule

//--- testbench/tb_tdc_ctrl.sv
`timescale 1ns/1ps

module tb_tdc_ctrl
  import tdc_ctrl_pkg::*;
();

  localparam int          RESET_CYCLES   = 16;
  localparam int          DRIVE_DELAY_NS = 5;
  localparam logic [31:0] RAND_SEED      = 32'hf600ebe5;
  // idle gap before a frame is 0 to 7 cycles
  localparam int          MAX_GAP        = 8;
  localparam int          IDLE_BITS      = 2;
  // enable comes back about 9.5 bit times after the start edge
  localparam int          RISE_EARLIEST  = CLK_PER_BIT * 19 / 2;
  localparam int          RISE_MARGIN    = 8;
  localparam int          SEQ_CYCLES     = BOOT_WAIT_CYCLES + SOFT_RESET_DELAY;
  localparam int          SETTLE_CYCLES  = 4;
  localparam logic [7:0]  CHAR_D         = 8'h64;
  localparam int          LINE_W         = 8 * 160;
  localparam int          TOK_W          = 8 * 32;
  localparam string       DATA_FILE      = "testbench/tdc_ctrl_testdata.txt";

  logic               clk;
  logic               rst;
  logic               serial_in;
  logic [NUM_TDC-1:0] tdc_enable;
  logic [NUM_TDC-1:0] soft_reset;
  logic               exit;
  logic               pause;

  // test vectors from the data file
  string      names[$];
  logic [7:0] bytes_q[$];
  int         good_q[$];
  int         pause_exp_q[$];
  int         exit_exp_q[$];
  int         seq_q[$];

  string cur_name       = "reset_state";
  int    cycle          = 0;
  int    watchdog_limit = 0;
  logic  monitor_on     = 1'b0;

  // edge tracking done by the output monitor
  logic en_prev         = 1'b0;
  logic dip_pending     = 1'b0;
  int   en_low_len      = 0;
  int   en_rises        = 0;
  int   en_falls        = 0;
  int   last_rise_cycle = 0;
  logic sr_prev         = 1'b0;
  int   sr_len          = 0;
  int   sr_pulses       = 0;

  tb_clock clk_gen (
    .clk (clk)
  );

  tdc_ctrl_top uut (
    .clk        (clk),
    .rst        (rst),
    .serial_in  (serial_in),
    .tdc_enable (tdc_enable),
    .soft_reset (soft_reset),
    .exit       (exit),
    .pause      (pause)
  );

  task automatic end_with_failure();
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
      end_with_failure();
    end
  endtask

  // a lone # token marks a comment line
  function automatic logic is_comment(input logic [TOK_W-1:0] tok);
    return (tok[7:0] == 8'h23) && (tok[TOK_W-1:8] == '0);
  endfunction

  task automatic wait_cycles(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      @(posedge clk);
      #(DRIVE_DELAY_NS);
    end
  endtask

  task automatic load_tests();
    int                fd;
    int                fields;
    logic [LINE_W-1:0] line_buf;
    logic [TOK_W-1:0]  name_vec;
    logic [7:0]        value;
    int                good;
    int                exp_pause;
    int                exp_exit;
    int                exp_seq;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the test data file %s", DATA_FILE);
      end_with_failure();
    end
    while ($fgets(line_buf, fd) != 0) begin
      name_vec = '0;
      fields = $sscanf(line_buf, "%s %h %d %d %d %d", name_vec, value, good,
                       exp_pause, exp_exit, exp_seq);
      if (fields == 6) begin
        names.push_back($sformatf("%0s", name_vec));
        bytes_q.push_back(value);
        good_q.push_back(good);
        pause_exp_q.push_back(exp_pause);
        exit_exp_q.push_back(exp_exit);
        seq_q.push_back(exp_seq);
      end else if (fields > 0 && !is_comment(name_vec)) begin
        $display("malformed line in the test data file: %0s", line_buf);
        end_with_failure();
      end
    end
    $fclose(fd);
    if (names.size() == 0) begin
      $display("the test data file holds no tests");
      end_with_failure();
    end
  endtask

  // 8n1 frame, lsb first; a bad frame gets a low stop bit
  task automatic send_frame(input logic [7:0] value, input logic good,
                            output int start_cycle);
    logic [9:0] shift;
    int         b;
    shift = {good, value, 1'b0};
    start_cycle = cycle;
    for (b = 0; b < 10; b++) begin
      serial_in = shift[0];
      shift = shift >> 1;
      wait_cycles(CLK_PER_BIT);
    end
    serial_in = 1'b1;
    wait_cycles(IDLE_BITS * CLK_PER_BIT);
  endtask

  task automatic run_test(input int idx);
    logic [NUM_TDC-1:0] enable_before;
    int                 rises_before;
    int                 falls_before;
    int                 pulses_before;
    int                 frame_start;
    int                 rise_delay;
    logic               power_on;
    cur_name = names[idx];
    enable_before = tdc_enable;
    rises_before = en_rises;
    falls_before = en_falls;
    pulses_before = sr_pulses;
    // only a good 'd' frame starts a sequence
    power_on = (good_q[idx] != 0) && (bytes_q[idx] == CHAR_D);

    wait_cycles(int'($urandom % MAX_GAP));
    send_frame(bytes_q[idx], good_q[idx] != 0, frame_start);

    if (power_on) begin
      check_value({cur_name, " enable rises"}, 32'(rises_before + 1), 32'(en_rises));
      check_value({cur_name, " enable falls"},
                  32'(falls_before + ((enable_before == '1) ? 1 : 0)), 32'(en_falls));
      rise_delay = last_rise_cycle - frame_start;
      if (rise_delay < RISE_EARLIEST || rise_delay > RISE_EARLIEST + RISE_MARGIN) begin
        $display("%s: enable rose %0d cycles after the start bit, outside its window",
                 cur_name, rise_delay);
        end_with_failure();
      end
      check_value({cur_name, " enable level"}, 32'({NUM_TDC{1'b1}}), 32'(tdc_enable));
    end else begin
      // enable untouched by anything else
      check_value({cur_name, " enable rises"}, 32'(rises_before), 32'(en_rises));
      check_value({cur_name, " enable falls"}, 32'(falls_before), 32'(en_falls));
      check_value({cur_name, " enable level"}, 32'(enable_before), 32'(tdc_enable));
    end
    check_value({cur_name, " pause"}, 32'(pause_exp_q[idx]), 32'(pause));
    check_value({cur_name, " exit"}, 32'(exit_exp_q[idx]), 32'(exit));

    if (seq_q[idx] != 0) begin
      // pulse timing itself is checked by the monitor
      while (sr_pulses == pulses_before) begin
        wait_cycles(1);
      end
      wait_cycles(SETTLE_CYCLES);
      check_value({cur_name, " soft reset pulses"}, 32'(pulses_before + 1), 32'(sr_pulses));
    end else begin
      check_value({cur_name, " soft reset pulses"}, 32'(pulses_before), 32'(sr_pulses));
    end
    check_value({cur_name, " soft reset level"}, 32'd0, 32'(soft_reset));
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // outputs sampled mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (monitor_on) begin
      // all channels share one enable and one reset
      if (tdc_enable != '0 && tdc_enable != '1) begin
        $display("%s: tdc enable channels disagree, bus is 0x%0h", cur_name, tdc_enable);
        end_with_failure();
      end
      if (soft_reset != '0 && soft_reset != '1) begin
        $display("%s: soft reset channels disagree, bus is 0x%0h", cur_name, soft_reset);
        end_with_failure();
      end

      if (en_prev && !tdc_enable[0]) begin
        en_falls = en_falls + 1;
        dip_pending = 1'b1;
        en_low_len = 0;
      end
      if (!tdc_enable[0]) begin
        en_low_len = en_low_len + 1;
      end
      if (!en_prev && tdc_enable[0]) begin
        en_rises = en_rises + 1;
        last_rise_cycle = cycle;
        // first rise after reset has no dip to measure
        if (dip_pending) begin
          check_value({cur_name, " enable low cycles"}, 32'd1, 32'(en_low_len));
          dip_pending = 1'b0;
        end
      end
      en_prev = tdc_enable[0];

      if (soft_reset[0]) begin
        if (!sr_prev) begin
          // pulse timed from the latest enable rise
          check_value({cur_name, " enable rise to soft reset"}, 32'(SEQ_CYCLES),
                      32'(cycle - last_rise_cycle));
          sr_len = 0;
        end
        sr_len = sr_len + 1;
      end else if (sr_prev) begin
        check_value({cur_name, " soft reset cycles"}, 32'd1, 32'(sr_len));
        sr_pulses = sr_pulses + 1;
      end
      sr_prev = soft_reset[0];
    end
  end

  // budget grows with the number of tests
  initial begin
    wait (watchdog_limit > 0);
    repeat (watchdog_limit) @(posedge clk);
    $display("timeout: outputs never settled");
    end_with_failure();
  end

  initial begin
    int idx;
    rst = 1'b1;
    serial_in = 1'b1;
    void'($urandom(RAND_SEED));
    load_tests();
    watchdog_limit = names.size() * (12 * CLK_PER_BIT + SEQ_CYCLES + 20) + 100;

    wait_cycles(RESET_CYCLES);
    rst = 1'b0;
    wait_cycles(SETTLE_CYCLES);
    // everything low after reset, line idle
    check_value("reset_state tdc_enable", 32'd0, 32'(tdc_enable));
    check_value("reset_state soft_reset", 32'd0, 32'(soft_reset));
    check_value("reset_state exit", 32'd0, 32'(exit));
    check_value("reset_state pause", 32'd0, 32'(pause));
    monitor_on = 1'b1;

    for (idx = 0; idx < names.size(); idx++) begin
      run_test(idx);
    end

    $display("test passed");
    $finish;
  end

endmodule

//--- compile.f
hw/tdc_ctrl_pkg.sv
hw/serial_rx.sv
hw/main_control.sv
hw/tdc_ctrl_top.sv
testbench/tb_clock.sv
testbench/tb_tdc_ctrl.sv

//--- run.sh
#!/bin/sh
# build the tdc control testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f compile.f --top-module tb_tdc_ctrl -o tb_tdc_ctrl_sim

# the run passes only if the pass line shows up in the output
./obj_dir/tb_tdc_ctrl_sim | tee /dev/stderr | grep -x "test passed" > /dev/null

//--- testbench/tdc_ctrl_testdata.txt
# name  byte(hex)  frame_good  exp_pause  exp_exit  exp_seq
# exp_seq 1 waits for the soft reset pulse that ends a power-on
power_on_first     64 1 0 0 1
pause_on           70 1 1 0 0
pause_off          70 1 0 0 0
exit_set           68 1 0 1 0
exit_hold          68 1 0 1 0
ignore_x           78 1 0 1 0
ignore_upper_d     44 1 0 1 0
ignore_upper_p     50 1 0 1 0
ignore_upper_h     48 1 0 1 0
ignore_high_d      e4 1 0 1 0
ignore_space       20 1 0 1 0
ignore_zero        00 1 0 1 0
ignore_ones        ff 1 0 1 0
power_on_clr_exit  64 1 0 0 1
bad_pause          70 0 0 0 0
pause_after_bad    70 1 1 0 0
bad_exit           68 0 1 0 0
bad_power_on       64 0 1 0 0
exit_after_bad     68 1 1 1 0
pause_off_again    70 1 0 1 0
restart_first      64 1 0 0 0
restart_second     64 1 0 0 1
seq_start          64 1 0 0 0
exit_in_seq        68 1 0 1 1
seq_again          64 1 0 0 0
pause_in_seq       70 1 1 0 1
pause_off_final    70 1 0 0 0
power_on_last      64 1 0 0 1
exit_final         68 1 0 1 0
pause_with_exit    70 1 1 1 0
ignore_newline     0a 1 1 1 0
pause_last         70 1 0 1 0
